//--- i2c_write.f
hw/i2c_cmd_pkg.sv
hw/i2c_bus_pkg.sv
hw/i2c_cmd_queue.sv
hw/i2c_bit_timer.sv
hw/i2c_write_master.sv
hw/i2c_write_top.sv
test/i2c_write_checker.sv
test/tb_i2c_write.sv

//--- test/tb_i2c_write.sv
`timescale 1ns/1ps

module tb_i2c_write
  import i2c_cmd_pkg::*;
;

  localparam int divider      = 4;
  localparam int depth        = 4;
  localparam int n_cmds       = 40;
  localparam int frame_cycles = 80 * divider;
  localparam int cycle_limit  = n_cmds * frame_cycles * 2;

  logic              clk;
  logic              rst;
  logic              cmd_valid;
  logic [addr_w-1:0] cmd_addr;
  logic [data_w-1:0] cmd_data;
  logic              cmd_drop;
  logic              scl_oe;
  logic              sda_oe;
  logic              done;
  logic              addr_ack;
  logic              data_ack;
  logic              slave_oe;
  logic              scl_line;
  logic              sda_line;
  int                errors;
  int                frames;
  int                drops;
  int                pending;
  int                tb_errors;
  int                cycles;
  logic [31:0]       lfsr;

  // Slave model state.
  logic              s_prev_scl;
  logic              s_prev_sda;
  logic              s_scl;
  logic              s_sda;
  logic              s_active;
  int                s_bits;
  int                s_bytes;
  logic [7:0]        s_shift;

  // Wired-AND bus with pull-ups.
  assign scl_line = ~scl_oe;
  assign sda_line = ~(sda_oe | slave_oe);

  i2c_write_top #(
    .divider(divider),
    .depth  (depth)
  ) i_i2c_write_top (
    .clk       (clk),
    .rst       (rst),
    .cmd_valid (cmd_valid),
    .cmd_addr  (cmd_addr),
    .cmd_data  (cmd_data),
    .sda_in    (sda_line),
    .cmd_drop  (cmd_drop),
    .scl_oe    (scl_oe),
    .sda_oe    (sda_oe),
    .done      (done),
    .addr_ack  (addr_ack),
    .data_ack  (data_ack)
  );

  i2c_write_checker #(
    .divider(divider),
    .depth  (depth)
  ) i_checker (
    .clk       (clk),
    .rst       (rst),
    .scl       (scl_line),
    .sda       (sda_line),
    .cmd_valid (cmd_valid),
    .cmd_addr  (cmd_addr),
    .cmd_data  (cmd_data),
    .cmd_drop  (cmd_drop),
    .done      (done),
    .addr_ack  (addr_ack),
    .data_ack  (data_ack),
    .errors    (errors),
    .frames    (frames),
    .drops     (drops),
    .pending   (pending)
  );

  initial
  begin
    clk = 1'b0;
    forever #10 clk = ~clk;
  end

  // Slave answers: address 7'h50 or 7'h2a, and any data byte but 8'hff.
  function automatic logic slave_acks(input int byte_idx, input logic [7:0] rx);
    if (byte_idx == 0)
      return (rx[7:1] == 7'h50) || (rx[7:1] == 7'h2a);
    if (byte_idx == 1)
      return rx != 8'hff;
    return 1'b0;
  endfunction

  initial
  begin
    slave_oe   = 1'b0;
    s_active   = 1'b0;
    s_prev_scl = 1'b1;
    s_prev_sda = 1'b1;
    forever
    begin
      @(posedge clk);
      #2;
      s_scl = scl_line;
      s_sda = sda_line;
      if (rst)
      begin
        s_active = 1'b0;
        slave_oe = 1'b0;
        s_scl    = 1'b1;
        s_sda    = 1'b1;
      end
      else if (s_prev_scl && s_scl && s_prev_sda && !s_sda)
      begin
        s_active = 1'b1; // START.
        s_bits   = 0;
        s_bytes  = 0;
      end
      else if (s_prev_scl && s_scl && !s_prev_sda && s_sda)
      begin
        s_active = 1'b0; // STOP.
        slave_oe = 1'b0;
      end
      else if (s_active && !s_prev_scl && s_scl)
      begin
        if (s_bits < 8)
          s_shift = {s_shift[6:0], s_sda};
        s_bits++;
      end
      else if (s_active && s_prev_scl && !s_scl)
      begin
        if (s_bits == 8)
          slave_oe = slave_acks(s_bytes, s_shift); // Drive the ACK bit.
        else if (s_bits == 9)
        begin
          slave_oe = 1'b0;
          s_bits   = 0;
          s_bytes++;
        end
      end
      s_prev_scl = s_scl;
      s_prev_sda = s_sda;
    end
  end

  function automatic logic [31:0] lfsr_next(input logic [31:0] s);
    return {s[30:0], s[31] ^ s[21] ^ s[1] ^ s[0]};
  endfunction

  task automatic take_bits(input int n, output logic [31:0] v);
    int k;
    v = '0;
    for (k = 0; k < n; k++)
    begin
      lfsr = lfsr_next(lfsr);
      v    = {v[30:0], lfsr[0]};
    end
  endtask

  task automatic pick_random_cmd(output logic [addr_w-1:0] a, output logic [data_w-1:0] d);
    logic [31:0] r;
    take_bits(1, r);
    if (r[0])
    begin
      take_bits(1, r);
      a = r[0] ? 7'h50 : 7'h2a; // One of the acknowledged pair.
    end
    else
    begin
      take_bits(addr_w, r);
      a = r[addr_w-1:0];
    end
    take_bits(data_w, r);
    d = r[data_w-1:0];
  endtask

  task automatic drive_cmd(input logic [addr_w-1:0] a, input logic [data_w-1:0] d);
    @(posedge clk);
    #2;
    cmd_valid = 1'b1;
    cmd_addr  = a;
    cmd_data  = d;
  endtask

  task automatic drive_idle();
    @(posedge clk);
    #2;
    cmd_valid = 1'b0;
  endtask

  task automatic wait_drain();
    while (pending != 0)
      @(posedge clk);
    repeat (8 * divider) @(posedge clk); // Bus stays idle after the last frame.
  endtask

  task automatic print_summary();
    $display("Summary: %0d checker errors, %0d testbench errors, %0d frames, %0d drops",
             errors, tb_errors, frames, drops);
  endtask

  initial
  begin
    int                i;
    int                drops_before;
    logic [31:0]       r;
    logic [addr_w-1:0] a;
    logic [data_w-1:0] d;
    rst       = 1'b1;
    cmd_valid = 1'b0;
    cmd_addr  = '0;
    cmd_data  = '0;
    tb_errors = 0;
    lfsr      = 32'h5afd_2af9;
    repeat (4) @(posedge clk);
    #2;
    rst = 1'b0;

    drive_cmd(7'h50, 8'h3c); // Fully acknowledged write.
    drive_idle();
    wait_drain();
    drive_cmd(7'h13, 8'ha5); // No slave at this address.
    drive_idle();
    wait_drain();
    drive_cmd(7'h2a, 8'hff); // Data byte refused.
    drive_idle();
    wait_drain();

    // Six strobes in a row overflow the four-entry queue.
    drops_before = drops;
    drive_cmd(7'h50, 8'h11);
    drive_cmd(7'h2a, 8'h22);
    drive_cmd(7'h31, 8'h33);
    drive_cmd(7'h50, 8'h44);
    drive_cmd(7'h2a, 8'h55);
    drive_cmd(7'h50, 8'h66);
    drive_idle();
    wait_drain();
    if (drops == drops_before)
    begin
      $display("Burst of six commands caused no queue overflow");
      tb_errors++;
    end

    for (i = 0; i < 30; i++)
    begin
      while (pending >= depth)
        @(posedge clk);
      pick_random_cmd(a, d);
      drive_cmd(a, d);
      drive_idle();
      take_bits(3, r);
      repeat (r[2:0]) @(posedge clk);
    end
    wait_drain();

    print_summary();
    if ((errors == 0) && (tb_errors == 0))
      $display("TESTS PASSED");
    else
      $display("TESTS FAILED");
    $finish;
  end

  initial
  begin
    cycles = 0;
    while (cycles < cycle_limit)
    begin
      @(posedge clk);
      cycles++;
    end
    $display("Timeout after %0d cycles with %0d commands still pending", cycles, pending);
    print_summary();
    $display("TESTS FAILED");
    $finish;
  end

endmodule

//--- test/i2c_write_checker.sv
`timescale 1ns/1ps

module i2c_write_checker
  import i2c_cmd_pkg::*;
#(
  parameter int divider = 4,
  parameter int depth   = default_depth
)
(
  input  logic              clk,
  input  logic              rst,
  input  logic              scl,
  input  logic              sda,
  input  logic              cmd_valid,
  input  logic [addr_w-1:0] cmd_addr,
  input  logic [data_w-1:0] cmd_data,
  input  logic              cmd_drop,
  input  logic              done,
  input  logic              addr_ack,
  input  logic              data_ack,
  output int                errors,
  output int                frames,
  output int                drops,
  output int                pending
);

  logic [cmd_w-1:0] exp_q [$]; // Accepted commands, in bus order.
  int               occ;       // Modelled queue occupancy.
  logic             free;      // Master may pop this cycle.
  int               gap_cnt;
  logic             drop_due;
  logic             in_frame;
  logic             stop_seen;
  logic             prev_scl;
  logic             prev_sda;
  logic [31:0]      obs_bits;
  int               obs_n;
  logic             exp_a;
  logic             exp_d;

  // Expected SDA bits sampled at each SCL rise after START, up to STOP.
  function automatic void expect_frame(
    input  logic [addr_w-1:0] addr,
    input  logic [data_w-1:0] data,
    output logic [31:0]       bits,
    output int                nbits,
    output logic              has_data,
    output logic              a_ack,
    output logic              d_ack
  );
    int i;
    a_ack    = (addr == 7'h50) || (addr == 7'h2a);
    d_ack    = a_ack && (data != 8'hff);
    has_data = a_ack;
    bits     = '0;
    nbits    = 0;
    for (i = addr_w - 1; i >= 0; i--)
    begin
      bits  = {bits[30:0], addr[i]};
      nbits = nbits + 1;
    end
    bits  = {bits[29:0], 1'b0, !a_ack}; // Write bit, then the slave's answer.
    nbits = nbits + 2;
    if (has_data)
    begin
      for (i = data_w - 1; i >= 0; i--)
      begin
        bits  = {bits[30:0], data[i]};
        nbits = nbits + 1;
      end
      bits  = {bits[30:0], !d_ack};
      nbits = nbits + 1;
    end
    bits  = {bits[30:0], 1'b0}; // SDA still low while SCL rises before STOP.
    nbits = nbits + 1;
  endfunction

  task automatic track_queue();
    logic pop_now;
    logic accept;
    if (gap_cnt != 0)
    begin
      gap_cnt--;
      if (gap_cnt == 0)
        free = 1'b1; // Bus-free bit after STOP has elapsed.
    end
    pop_now = free && (occ != 0);
    accept  = cmd_valid && ((occ < depth) || pop_now);
    if (cmd_drop !== drop_due)
    begin
      $display("Mismatch cmd_drop: got %h, expected %h at %0t", cmd_drop, drop_due, $time);
      errors++;
    end
    if (cmd_drop === 1'b1)
      drops++;
    drop_due = cmd_valid && !accept;
    if (accept)
    begin
      exp_q.push_back({cmd_addr, cmd_data});
      occ++;
    end
    if (pop_now)
    begin
      occ--;
      free = 1'b0;
    end
  endtask

  task automatic track_done();
    if (done === 1'b1)
    begin
      if (!stop_seen)
      begin
        $display("Done strobe at %0t without a STOP in the cycle before", $time);
        errors++;
      end
      else
      begin
        if (addr_ack !== exp_a)
        begin
          $display("Mismatch addr_ack: got %h, expected %h at %0t", addr_ack, exp_a, $time);
          errors++;
        end
        if (data_ack !== exp_d)
        begin
          $display("Mismatch data_ack: got %h, expected %h at %0t", data_ack, exp_d, $time);
          errors++;
        end
        void'(exp_q.pop_front());
        frames++;
        gap_cnt = 4 * divider - 1;
      end
    end
    else if (stop_seen)
    begin
      $display("No done strobe one cycle after the STOP at %0t", $time);
      errors++;
    end
    stop_seen = 1'b0;
  endtask

  task automatic track_bus();
    logic [addr_w-1:0] a;
    logic [data_w-1:0] d;
    logic [31:0]       exp_bits;
    int                exp_n;
    logic              has_data;
    if (scl && prev_scl && (sda != prev_sda))
    begin
      if (!sda && !in_frame)
      begin
        in_frame = 1'b1; // START.
        obs_bits = '0;
        obs_n    = 0;
      end
      else if (sda && in_frame)
      begin
        in_frame = 1'b0; // STOP.
        if (exp_q.size() == 0)
        begin
          $display("Frame ended at %0t although no command was accepted", $time);
          errors++;
        end
        else
        begin
          {a, d} = exp_q[0];
          expect_frame(a, d, exp_bits, exp_n, has_data, exp_a, exp_d);
          if (obs_n != exp_n)
            $display("Mismatch sda bit count: got %h, expected %h (address %h, data byte %0d)",
                     obs_n, exp_n, a, has_data);
          else if (obs_bits !== exp_bits)
            $display("Mismatch sda bits: got %h, expected %h (address %h, data %h)",
                     obs_bits, exp_bits, a, d);
          if ((obs_n != exp_n) || (obs_bits !== exp_bits))
            errors++;
          stop_seen = 1'b1;
        end
      end
      else
      begin
        $display("SDA changed while SCL was high at %0t, outside START and STOP", $time);
        errors++;
      end
    end
    else if (in_frame && scl && !prev_scl)
    begin
      obs_bits = {obs_bits[30:0], sda};
      obs_n++;
    end
    if (!in_frame && ((scl !== 1'b1) || (sda !== 1'b1)))
    begin
      $display("Bus not released outside a frame at %0t", $time);
      errors++;
    end
  endtask

  initial
  begin
    errors  = 0;
    frames  = 0;
    drops   = 0;
    pending = 0;
  end

  // All DUT and slave outputs are settled by mid-cycle.
  always @(negedge clk)
  begin
    if (rst)
    begin
      occ       = 0;
      free      = 1'b1;
      gap_cnt   = 0;
      drop_due  = 1'b0;
      in_frame  = 1'b0;
      stop_seen = 1'b0;
      prev_scl  = 1'b1;
      prev_sda  = 1'b1;
      obs_bits  = '0;
      obs_n     = 0;
      exp_q.delete();
    end
    else
    begin
      track_queue();
      track_done();
      track_bus();
      prev_scl = scl;
      prev_sda = sda;
    end
    pending = exp_q.size();
  end

endmodule

//--- hw/i2c_write_top.sv
`timescale 1ns/1ps

module i2c_write_top
  import i2c_cmd_pkg::*, i2c_bus_pkg::*;
#(
  parameter int divider = 4,
  parameter int depth   = default_depth
)
(
  input  logic              clk,
  input  logic              rst,
  input  logic              cmd_valid,
  input  logic [addr_w-1:0] cmd_addr,
  input  logic [data_w-1:0] cmd_data,
  input  logic              sda_in,
  output logic              cmd_drop,
  output logic              scl_oe,
  output logic              sda_oe,
  output logic              done,
  output logic              addr_ack,
  output logic              data_ack
);

  logic [addr_w-1:0]           head_addr;
  logic [data_w-1:0]           head_data;
  logic                        not_empty;
  logic                        pop;
  logic                        run;
  logic                        tick;
  logic [$clog2(quarters)-1:0] quarter;

  // Pending commands from the host.
  i2c_cmd_queue #(
    .depth(depth)
  ) i_i2c_cmd_queue (
    .clk       (clk),
    .rst       (rst),
    .push      (cmd_valid),
    .push_addr (cmd_addr),
    .push_data (cmd_data),
    .pop       (pop),
    .head_addr (head_addr),
    .head_data (head_data),
    .not_empty (not_empty),
    .drop      (cmd_drop)
  );

  i2c_bit_timer #(
    .divider(divider)
  ) i_i2c_bit_timer (
    .clk     (clk),
    .rst     (rst),
    .run     (run),
    .tick    (tick),
    .quarter (quarter)
  );

  i2c_write_master i_i2c_write_master (
    .clk       (clk),
    .rst       (rst),
    .not_empty (not_empty),
    .head_addr (head_addr),
    .head_data (head_data),
    .tick      (tick),
    .quarter   (quarter),
    .sda_in    (sda_in),
    .pop       (pop),
    .run       (run),
    .scl_oe    (scl_oe),
    .sda_oe    (sda_oe),
    .done      (done),
    .addr_ack  (addr_ack),
    .data_ack  (data_ack)
  );

endmodule

//--- hw/i2c_write_master.sv
`timescale 1ns/1ps

module i2c_write_master
  import i2c_cmd_pkg::*, i2c_bus_pkg::*;
(
  input  logic                        clk,
  input  logic                        rst,
  input  logic                        not_empty,
  input  logic [addr_w-1:0]           head_addr,
  input  logic [data_w-1:0]           head_data,
  input  logic                        tick,
  input  logic [$clog2(quarters)-1:0] quarter,
  input  logic                        sda_in,
  output logic                        pop,
  output logic                        run,
  output logic                        scl_oe,
  output logic                        sda_oe,
  output logic                        done,
  output logic                        addr_ack,
  output logic                        data_ack
);

  localparam int q_w   = $clog2(quarters);
  localparam int bit_w = $clog2(data_w);

  localparam logic [q_w-1:0] q_last   = q_w'(quarters - 1);
  localparam logic [q_w-1:0] q_sample = q_w'(2);            // SCL high, slave data stable.
  localparam logic [q_w-1:0] q_high   = q_w'(quarters / 2); // First quarter with SCL released.

  seq_phase_t        phase;
  logic [bit_w-1:0]  bit_cnt;
  logic [addr_w-1:0] cur_addr;
  logic [data_w-1:0] cur_data;
  logic              finish;
  logic              bit_end;
  logic              sample;

  assign bit_end = tick && (quarter == q_last);
  assign sample  = tick && (quarter == q_sample);

  // A new frame may start only once the bus-free gap has run out.
  assign pop = (phase == ph_idle) && !run && not_empty;

  // Own copy of the command, so the queue slot is free during the frame.
  always_ff @(posedge clk)
  begin
    if (pop)
    begin
      cur_addr <= head_addr;
      cur_data <= head_data;
    end
  end

  always_ff @(posedge clk)
  begin
    if (rst)
    begin
      phase    <= ph_idle;
      run      <= 1'b0;
      bit_cnt  <= '0;
      addr_ack <= 1'b0;
      data_ack <= 1'b0;
      finish   <= 1'b0;
      done     <= 1'b0;
    end
    else
    begin
      finish <= 1'b0;
      done   <= finish; // One cycle after the STOP release.

      if (pop)
      begin
        phase    <= ph_start;
        run      <= 1'b1;
        addr_ack <= 1'b0;
        data_ack <= 1'b0;
      end

      if (sample)
      begin
        if (phase == ph_ack_addr)
          addr_ack <= !sda_in; // Slave pulls SDA low to acknowledge.
        if (phase == ph_ack_data)
          data_ack <= !sda_in;
      end

      if (bit_end)
      begin
        case (phase)
          ph_idle:
          begin
            run <= 1'b0; // Bus-free bit time after STOP is over.
          end
          ph_start:
          begin
            phase   <= ph_addr;
            bit_cnt <= bit_w'(addr_w - 1);
          end
          ph_addr:
          begin
            if (bit_cnt == '0)
              phase <= ph_rw;
            else
              bit_cnt <= bit_cnt - 1'b1;
          end
          ph_rw:
          begin
            phase <= ph_ack_addr;
          end
          ph_ack_addr:
          begin
            // No data byte for an absent slave.
            if (addr_ack)
            begin
              phase   <= ph_data;
              bit_cnt <= bit_w'(data_w - 1);
            end
            else
            begin
              phase <= ph_stop;
            end
          end
          ph_data:
          begin
            if (bit_cnt == '0)
              phase <= ph_ack_data;
            else
              bit_cnt <= bit_cnt - 1'b1;
          end
          ph_ack_data:
          begin
            phase <= ph_stop;
          end
          ph_stop:
          begin
            phase  <= ph_idle; // SDA rises here with SCL high.
            finish <= 1'b1;
          end
          default:
          begin
            phase <= ph_idle;
          end
        endcase
      end
    end
  end

  // Open-drain enables; 1 pulls the line low.
  always_comb
  begin
    scl_oe = 1'b0;
    sda_oe = 1'b0;
    case (phase)
      ph_idle:
      begin
        scl_oe = 1'b0;
        sda_oe = 1'b0;
      end
      ph_start:
      begin
        // SDA falls in quarter 1 while SCL is still high.
        scl_oe = (quarter == q_last);
        sda_oe = (quarter != '0);
      end
      ph_addr:
      begin
        scl_oe = (quarter < q_high);
        sda_oe = !cur_addr[bit_cnt];
      end
      ph_rw:
      begin
        scl_oe = (quarter < q_high);
        sda_oe = 1'b1; // Write.
      end
      ph_data:
      begin
        scl_oe = (quarter < q_high);
        sda_oe = !cur_data[bit_cnt];
      end
      ph_stop:
      begin
        scl_oe = (quarter < q_high);
        sda_oe = 1'b1; // Held low until the bit ends.
      end
      default:
      begin
        // ACK bits, SDA left to the slave.
        scl_oe = (quarter < q_high);
        sda_oe = 1'b0;
      end
    endcase
  end

endmodule

//--- hw/i2c_bit_timer.sv
`timescale 1ns/1ps

module i2c_bit_timer
  import i2c_bus_pkg::*;
#(
  parameter int divider = 4
)
(
  input  logic                         clk,
  input  logic                         rst,
  input  logic                         run,
  output logic                         tick,
  output logic [$clog2(quarters)-1:0]  quarter
);

  localparam int cnt_w = $clog2(divider);
  localparam int q_w   = $clog2(quarters);

  logic [cnt_w-1:0] cnt;

  // Last cycle of the current quarter.
  assign tick = run && (cnt == cnt_w'(divider - 1));

  always_ff @(posedge clk)
  begin
    if (rst || !run)
    begin
      // Held clear between frames so the next one starts on quarter 0.
      cnt     <= '0;
      quarter <= '0;
    end
    else if (tick)
    begin
      cnt <= '0;
      if (quarter == q_w'(quarters - 1))
        quarter <= '0;
      else
        quarter <= quarter + 1'b1;
    end
    else
    begin
      cnt <= cnt + 1'b1;
    end
  end

endmodule

//--- hw/i2c_cmd_queue.sv
`timescale 1ns/1ps

module i2c_cmd_queue
  import i2c_cmd_pkg::*;
#(
  parameter int depth = default_depth
)
(
  input  logic              clk,
  input  logic              rst,
  input  logic              push,
  input  logic [addr_w-1:0] push_addr,
  input  logic [data_w-1:0] push_data,
  input  logic              pop,
  output logic [addr_w-1:0] head_addr,
  output logic [data_w-1:0] head_data,
  output logic              not_empty,
  output logic              drop
);

  localparam int ptr_w = (depth > 1) ? $clog2(depth) : 1;

  logic [cmd_w-1:0] mem [depth];
  logic [ptr_w-1:0] rd_ptr;
  logic [ptr_w-1:0] wr_ptr;
  logic [ptr_w:0]   count;
  logic             full;
  logic             do_pop;
  logic             do_push;

  assign full      = (count == (ptr_w + 1)'(depth));
  assign not_empty = (count != '0);
  assign do_pop    = pop && not_empty;
  assign do_push   = push && (!full || do_pop); // A pop frees the slot in the same cycle.

  assign {head_addr, head_data} = mem[rd_ptr];

  always_ff @(posedge clk)
  begin
    if (do_push)
      mem[wr_ptr] <= {push_addr, push_data};
  end

  always_ff @(posedge clk)
  begin
    if (rst)
    begin
      rd_ptr <= '0;
      wr_ptr <= '0;
      count  <= '0;
      drop   <= 1'b0;
    end
    else
    begin
      drop <= push && !do_push; // Command lost, contents untouched.
      if (do_push)
        wr_ptr <= (wr_ptr == ptr_w'(depth - 1)) ? '0 : wr_ptr + 1'b1;
      if (do_pop)
        rd_ptr <= (rd_ptr == ptr_w'(depth - 1)) ? '0 : rd_ptr + 1'b1;
      if (do_push && !do_pop)
        count <= count + 1'b1;
      else if (do_pop && !do_push)
        count <= count - 1'b1;
    end
  end

endmodule

//--- hw/i2c_bus_pkg.sv
package i2c_bus_pkg;

  // Sequencer phases, one per section of a write frame.
  typedef enum logic [2:0] {
    ph_idle     = 3'd0, // Bus free, or the bus-free gap after STOP.
    ph_start    = 3'd1,
    ph_addr     = 3'd2, // Seven address bits, MSB first.
    ph_rw       = 3'd3,
    ph_ack_addr = 3'd4,
    ph_data     = 3'd5, // Eight data bits, MSB first.
    ph_ack_data = 3'd6,
    ph_stop     = 3'd7
  } seq_phase_t;

  // Each bit on the bus is split into this many timer ticks.
  // SCL is low in the first half and released in the second half.
  localparam int quarters = 4;

endpackage

//--- hw/i2c_cmd_pkg.sv
package i2c_cmd_pkg;

  // Field widths of a queued write command.
  localparam int addr_w = 7;              // 7-bit slave address.
  localparam int data_w = 8;              // One data byte.
  localparam int cmd_w  = addr_w + data_w; // Packed entry width in the queue.

  // Commands that can wait while a frame is on the bus.
  localparam int default_depth = 4;

endpackage
